/* Bender.yml */
package:
  name: exu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/exu_pkg.sv
      - hdl/exu_alu.sv
      - hdl/exu_csr_file.sv
      - hdl/exu_branch_unit.sv
      - hdl/exu_stage.sv
      - hdl/exu_lsu.sv
      - hdl/exu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/exu_asserts.sv
      - testbench/exu_tb.sv

/* hdl/exu_alu.sv */
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0] a_i,
  input  logic [`EXU_XLEN-1:0] b_i,
  input  exu_pkg::alu_op_e     op_i,
  output logic [`EXU_XLEN-1:0] res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ADD:     res_o = a_i + b_i;
      SUB:     res_o = a_i - b_i;
      XOR:     res_o = a_i ^ b_i;
      OR:      res_o = a_i | b_i;
      AND:     res_o = a_i & b_i;
      SLL:     res_o = a_i << shamt;
      SRL:     res_o = a_i >> shamt;
      SRA:     res_o = $unsigned($signed(a_i) >>> shamt);
      // compares return a single flag bit.
      SLT:     res_o = {{(`EXU_XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      SLTU:    res_o = {{(`EXU_XLEN-1){1'b0}}, a_i < b_i};
      SGE:     res_o = {{(`EXU_XLEN-1){1'b0}}, $signed(a_i) >= $signed(b_i)};
      SGEU:    res_o = {{(`EXU_XLEN-1){1'b0}}, a_i >= b_i};
      default: res_o = '0;
    endcase
  end

endmodule

/* hdl/exu_branch_unit.sv */
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_branch_unit (
  input  exu_pkg::instr_class_e cls_i,
  input  exu_pkg::alu_op_e      alu_op_i,
  input  exu_pkg::sys_op_e      sys_op_i,
  input  logic [`EXU_XLEN-1:0]  alu_res_i,
  input  logic [`EXU_XLEN-1:0]  pc_i,
  input  logic [`EXU_XLEN-1:0]  target_i,
  input  logic [`EXU_XLEN-1:0]  mtvec_i,
  input  logic [`EXU_XLEN-1:0]  mepc_i,
  output logic [`EXU_XLEN-1:0]  npc_o
);
  import exu_pkg::*;

  logic taken;

  // sub compares for equality, the rest give a set flag when taken.
  always_comb begin
    case (alu_op_i)
      SUB:                          taken = ~|alu_res_i;
      XOR, SLT, SLTU, SGE, SGEU:    taken = |alu_res_i;
      default:                      taken = 1'b0;
    endcase
  end

  always_comb begin
    npc_o = pc_i + `EXU_XLEN'd4;
    case (cls_i)
      CLS_JUMP:   npc_o = target_i;
      CLS_BRANCH: begin
        if (taken) begin
          npc_o = target_i;
        end
      end
      CLS_SYSTEM: begin
        if (sys_op_i == SYS_ECALL) begin
          npc_o = mtvec_i;
        end else if (sys_op_i == SYS_MRET) begin
          npc_o = mepc_i;
        end
      end
      default: ;
    endcase
  end

endmodule

/* hdl/exu_csr_file.sv */
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_csr_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [11:0]          addr_i,
  input  exu_pkg::sys_op_e     sys_op_i,
  input  logic [`EXU_XLEN-1:0] wdata_i,
  input  logic [`EXU_XLEN-1:0] pc_i,
  input  logic                 commit_i,
  output logic [`EXU_XLEN-1:0] rdata_o,
  output logic [`EXU_XLEN-1:0] mtvec_o,
  output logic [`EXU_XLEN-1:0] mepc_o
);
  import exu_pkg::*;

  logic [`EXU_XLEN-1:0] mstatus_q;
  logic [`EXU_XLEN-1:0] mtvec_q;
  logic [`EXU_XLEN-1:0] mepc_q;
  logic [`EXU_XLEN-1:0] mcause_q;

  // unknown addresses read as zero.
  always_comb begin
    case (addr_i)
      `EXU_CSR_MSTATUS: rdata_o = mstatus_q;
      `EXU_CSR_MTVEC:   rdata_o = mtvec_q;
      `EXU_CSR_MEPC:    rdata_o = mepc_q;
      `EXU_CSR_MCAUSE:  rdata_o = mcause_q;
      default:          rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (commit_i) begin
      case (sys_op_i)
        SYS_CSRRW, SYS_CSRRS, SYS_CSRRC: begin
          case (addr_i)
            `EXU_CSR_MSTATUS: mstatus_q <= wdata_i;
            `EXU_CSR_MTVEC:   mtvec_q   <= wdata_i;
            `EXU_CSR_MEPC:    mepc_q    <= wdata_i;
            `EXU_CSR_MCAUSE:  mcause_q  <= wdata_i;
            default:          ;
          endcase
        end
        SYS_ECALL: begin
          mepc_q   <= pc_i;
          mcause_q <= `EXU_CAUSE_ECALL;
        end
        // mpie back into mie, then mpie set.
        SYS_MRET: begin
          mstatus_q[3] <= mstatus_q[7];
          mstatus_q[7] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

/* hdl/exu_lsu.sv */
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_lsu (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [`EXU_XLEN-1:0] addr_i,
  input  logic [`EXU_XLEN-1:0] wdata_i,
  output logic                 rvalid_o,
  output logic [`EXU_XLEN-1:0] rdata_o
);

  localparam int IDX_W = $clog2(`EXU_DMEM_WORDS);

  logic [`EXU_XLEN-1:0] mem [`EXU_DMEM_WORDS];
  logic [IDX_W-1:0]     idx;

  // word index, byte offset dropped.
  assign idx = addr_i[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (req_i) begin
      if (we_i) begin
        mem[idx] <= wdata_i;
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

  // one answer per request, fixed latency of one cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

/* hdl/exu_pkg.sv */
package exu_pkg;

  // kind of instruction held by the stage.
  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JUMP,
    CLS_SYSTEM
  } instr_class_e;

  // alu operations, the compares give 0 or 1.
  typedef enum logic [3:0] {
    ADD, SUB, XOR, OR, AND,
    SLL, SRL, SRA,
    SLT, SLTU, SGE, SGEU
  } alu_op_e;

  // system operations, immediate csr forms share the register forms.
  typedef enum logic [2:0] {
    SYS_NONE,
    SYS_ECALL,
    SYS_EBREAK,
    SYS_MRET,
    SYS_CSRRW,
    SYS_CSRRS,
    SYS_CSRRC
  } sys_op_e;

  // stage control states.
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM,
    ST_DONE
  } exu_state_e;

endpackage

/* hdl/exu_settings.svh */
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// data and address width.
`define EXU_XLEN 32

// scratchpad size in words.
`define EXU_DMEM_WORDS 256

// machine csr addresses.
`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC   12'h305
`define EXU_CSR_MEPC    12'h341
`define EXU_CSR_MCAUSE  12'h342

// mcause value for an environment call from m-mode.
`define EXU_CAUSE_ECALL 32'd11

`endif

/* hdl/exu_stage.sv */
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  exu_pkg::instr_class_e cls_i,
  input  exu_pkg::alu_op_e      alu_op_i,
  input  exu_pkg::sys_op_e      sys_op_i,
  input  logic [4:0]            rd_i,
  input  logic                  rd_wen_i,
  input  logic [`EXU_XLEN-1:0]  src1_i,
  input  logic [`EXU_XLEN-1:0]  src2_i,
  input  logic [`EXU_XLEN-1:0]  base_i,
  input  logic [`EXU_XLEN-1:0]  imm_i,
  input  logic [`EXU_XLEN-1:0]  pc_i,
  input  logic [11:0]           csr_addr_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [4:0]            rd_o,
  output logic                  rd_wen_o,
  output logic [`EXU_XLEN-1:0]  rd_wdata_o,
  output logic [`EXU_XLEN-1:0]  npc_o,
  output logic                  ebreak_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [`EXU_XLEN-1:0]  mem_addr_o,
  output logic [`EXU_XLEN-1:0]  mem_wdata_o,
  input  logic                  mem_rvalid_i,
  input  logic [`EXU_XLEN-1:0]  mem_rdata_i
);
  import exu_pkg::*;

  exu_state_e           state_q;
  instr_class_e         cls_q;
  alu_op_e              alu_op_q;
  sys_op_e              sys_op_q;
  logic [4:0]           rd_q;
  logic                 rd_wen_q;
  logic [`EXU_XLEN-1:0] src1_q;
  logic [`EXU_XLEN-1:0] src2_q;
  logic [`EXU_XLEN-1:0] pc_q;
  logic [`EXU_XLEN-1:0] target_q;
  logic [`EXU_XLEN-1:0] load_q;
  logic [11:0]          csr_addr_q;

  logic                 accept;
  logic                 retire;
  logic                 csr_commit;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] csr_rdata;
  logic [`EXU_XLEN-1:0] csr_wdata;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] load_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake and control.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign in_ready_o  = (state_q == ST_IDLE);
  assign out_valid_o = (state_q == ST_DONE);
  assign accept      = in_valid_i & in_ready_o;
  assign retire      = out_valid_o & out_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            state_q <= (cls_i == CLS_LOAD || cls_i == CLS_STORE) ? ST_MEM : ST_DONE;
          end
        end
        // the scratchpad answers in the first done cycle.
        ST_MEM:  state_q <= ST_DONE;
        ST_DONE: begin
          if (retire) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cls_q      <= cls_i;
      alu_op_q   <= alu_op_i;
      sys_op_q   <= sys_op_i;
      rd_q       <= rd_i;
      rd_wen_q   <= rd_wen_i;
      src1_q     <= src1_i;
      src2_q     <= src2_i;
      pc_q       <= pc_i;
      csr_addr_q <= csr_addr_i;
      target_q   <= base_i + imm_i;
    end
    if (mem_rvalid_i) begin
      load_q <= mem_rdata_i;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory request.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign mem_req_o   = (state_q == ST_MEM);
  assign mem_we_o    = mem_req_o && (cls_q == CLS_STORE);
  assign mem_addr_o  = target_q;
  assign mem_wdata_o = src2_q;

  // forward the word in its arrival cycle, hold it afterwards.
  assign load_data = mem_rvalid_i ? mem_rdata_i : load_q;

  exu_alu u_alu (
    .a_i   (src1_q),
    .b_i   (src2_q),
    .op_i  (alu_op_q),
    .res_o (alu_res)
  );

  exu_branch_unit u_branch (
    .cls_i     (cls_q),
    .alu_op_i  (alu_op_q),
    .sys_op_i  (sys_op_q),
    .alu_res_i (alu_res),
    .pc_i      (pc_q),
    .target_i  (target_q),
    .mtvec_i   (mtvec),
    .mepc_i    (mepc),
    .npc_o     (npc_o)
  );

  // csrs change only when the instruction retires.
  assign csr_commit = retire && (cls_q == CLS_SYSTEM);

  always_comb begin
    case (sys_op_q)
      SYS_CSRRS: csr_wdata = csr_rdata | src1_q;
      SYS_CSRRC: csr_wdata = csr_rdata & ~src1_q;
      default:   csr_wdata = src1_q;
    endcase
  end

  exu_csr_file u_csr (
    .clk      (clk),
    .rst      (rst),
    .addr_i   (csr_addr_q),
    .sys_op_i (sys_op_q),
    .wdata_i  (csr_wdata),
    .pc_i     (pc_q),
    .commit_i (csr_commit),
    .rdata_o  (csr_rdata),
    .mtvec_o  (mtvec),
    .mepc_o   (mepc)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // writeback.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (cls_q)
      CLS_LOAD:   rd_wdata_o = load_data;
      CLS_SYSTEM: rd_wdata_o = csr_rdata;
      CLS_JUMP:   rd_wdata_o = pc_q + `EXU_XLEN'd4;
      default:    rd_wdata_o = alu_res;
    endcase
  end

  assign rd_o     = rd_q;
  assign rd_wen_o = rd_wen_q;
  assign ebreak_o = out_valid_o && (cls_q == CLS_SYSTEM) && (sys_op_q == SYS_EBREAK);

endmodule

/* hdl/exu_top.sv */
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  exu_pkg::instr_class_e cls_i,
  input  exu_pkg::alu_op_e      alu_op_i,
  input  exu_pkg::sys_op_e      sys_op_i,
  input  logic [4:0]            rd_i,
  input  logic                  rd_wen_i,
  input  logic [`EXU_XLEN-1:0]  src1_i,
  input  logic [`EXU_XLEN-1:0]  src2_i,
  input  logic [`EXU_XLEN-1:0]  base_i,
  input  logic [`EXU_XLEN-1:0]  imm_i,
  input  logic [`EXU_XLEN-1:0]  pc_i,
  input  logic [11:0]           csr_addr_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [4:0]            rd_o,
  output logic                  rd_wen_o,
  output logic [`EXU_XLEN-1:0]  rd_wdata_o,
  output logic [`EXU_XLEN-1:0]  npc_o,
  output logic                  ebreak_o
);

  logic                 mem_req;
  logic                 mem_we;
  logic [`EXU_XLEN-1:0] mem_addr;
  logic [`EXU_XLEN-1:0] mem_wdata;
  logic                 mem_rvalid;
  logic [`EXU_XLEN-1:0] mem_rdata;

  exu_stage u_stage (
    .clk          (clk),
    .rst          (rst),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .cls_i        (cls_i),
    .alu_op_i     (alu_op_i),
    .sys_op_i     (sys_op_i),
    .rd_i         (rd_i),
    .rd_wen_i     (rd_wen_i),
    .src1_i       (src1_i),
    .src2_i       (src2_i),
    .base_i       (base_i),
    .imm_i        (imm_i),
    .pc_i         (pc_i),
    .csr_addr_i   (csr_addr_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .rd_o         (rd_o),
    .rd_wen_o     (rd_wen_o),
    .rd_wdata_o   (rd_wdata_o),
    .npc_o        (npc_o),
    .ebreak_o     (ebreak_o),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata)
  );

  exu_lsu u_lsu (
    .clk      (clk),
    .rst      (rst),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

endmodule

/* testbench/exu_asserts.sv */
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_asserts (
  input logic                  clk,
  input logic                  rst,
  input logic                  in_valid_i,
  input logic                  in_ready_o,
  input exu_pkg::instr_class_e cls_i,
  input logic                  out_valid_o,
  input logic                  out_ready_i,
  input logic [4:0]            rd_o,
  input logic                  rd_wen_o,
  input logic [`EXU_XLEN-1:0]  rd_wdata_o,
  input logic [`EXU_XLEN-1:0]  npc_o,
  input logic                  ebreak_o,
  input logic                  mem_req_i
);
  import exu_pkg::*;

  int   fail_count = 0;
  logic accept;
  logic mem_cls;

  assign accept  = in_valid_i && in_ready_o;
  assign mem_cls = (cls_i == CLS_LOAD) || (cls_i == CLS_STORE);

  a_not_both: assert property (@(posedge clk) disable iff (rst)
    !(in_ready_o && out_valid_o))
    else begin
      fail_count++;
      $error("in_ready_o and out_valid_o are high together");
    end

  // writeback held while downstream stalls.
  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(rd_o) && $stable(rd_wen_o)
      && $stable(rd_wdata_o) && $stable(npc_o) && $stable(ebreak_o))
    else begin
      fail_count++;
      $error("writeback changed during a stall");
    end

  a_alu_latency: assert property (@(posedge clk) disable iff (rst)
    accept && !mem_cls |=> out_valid_o)
    else begin
      fail_count++;
      $error("non-memory instruction not valid one cycle after acceptance");
    end

  a_mem_latency: assert property (@(posedge clk) disable iff (rst)
    accept && mem_cls |=> mem_req_i ##1 out_valid_o)
    else begin
      fail_count++;
      $error("memory instruction missed its request or writeback cycle");
    end

  a_req_pulse: assert property (@(posedge clk) disable iff (rst)
    mem_req_i |=> !mem_req_i)
    else begin
      fail_count++;
      $error("mem_req lasted more than one cycle");
    end

endmodule

bind exu_top exu_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .in_valid_i  (in_valid_i),
  .in_ready_o  (in_ready_o),
  .cls_i       (cls_i),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .rd_o        (rd_o),
  .rd_wen_o    (rd_wen_o),
  .rd_wdata_o  (rd_wdata_o),
  .npc_o       (npc_o),
  .ebreak_o    (ebreak_o),
  .mem_req_i   (mem_req)
);

/* testbench/exu_tb.sv */
`timescale 1ns/100ps
`include "exu_settings.svh"

module exu_tb;
  import exu_pkg::*;

  localparam int XL       = `EXU_XLEN;
  localparam int N_ALU    = 40;
  localparam int N_MEM    = 16;
  localparam int N_ROUNDS = 3;
  // alu, branches and jumps, stores and loads, csr sequence, stalled rounds.
  localparam int N_INSTR  = N_ALU + 22 + 2 * N_MEM + 19 + 8 * N_ROUNDS;

  logic          clk;
  logic          rst;
  logic          in_valid_i;
  logic          in_ready_o;
  instr_class_e  cls_i;
  alu_op_e       alu_op_i;
  sys_op_e       sys_op_i;
  logic [4:0]    rd_i;
  logic          rd_wen_i;
  logic [XL-1:0] src1_i;
  logic [XL-1:0] src2_i;
  logic [XL-1:0] base_i;
  logic [XL-1:0] imm_i;
  logic [XL-1:0] pc_i;
  logic [11:0]   csr_addr_i;
  logic          out_valid_o;
  logic          out_ready_i;
  logic [4:0]    rd_o;
  logic          rd_wen_o;
  logic [XL-1:0] rd_wdata_o;
  logic [XL-1:0] npc_o;
  logic          ebreak_o;

  integer        seed;
  int            errors;
  int            stall_max;
  logic [XL-1:0] shadow_mem [`EXU_DMEM_WORDS];
  logic [XL-1:0] sh_mstatus;
  logic [XL-1:0] sh_mtvec;
  logic [XL-1:0] sh_mepc;
  logic [XL-1:0] sh_mcause;
  logic [XL-1:0] addr_q [$];
  alu_op_e       br_ops [6] = '{SUB, XOR, SLT, SLTU, SGE, SGEU};

  exu_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [XL-1:0] alu_model(alu_op_e op, logic [XL-1:0] a,
                                              logic [XL-1:0] b);
    logic [4:0] sh;
    logic       lt_s;
    logic       lt_u;
    sh   = b[4:0];
    lt_u = (a < b);
    // flipped sign bits turn the signed compare into an unsigned one.
    lt_s = ({~a[XL-1], a[XL-2:0]} < {~b[XL-1], b[XL-2:0]});
    case (op)
      ADD:     return a + b;
      SUB:     return a + ~b + 1;
      XOR:     return a ^ b;
      OR:      return a | b;
      AND:     return a & b;
      SLL:     return a << sh;
      SRL:     return a >> sh;
      SRA:     return (a >> sh) | (a[XL-1] ? ~({XL{1'b1}} >> sh) : '0);
      SLT:     return XL'(lt_s);
      SLTU:    return XL'(lt_u);
      SGE:     return XL'(!lt_s);
      SGEU:    return XL'(!lt_u);
      default: return '0;
    endcase
  endfunction

  function automatic logic [XL-1:0] csr_model(logic [11:0] addr);
    case (addr)
      `EXU_CSR_MSTATUS: return sh_mstatus;
      `EXU_CSR_MTVEC:   return sh_mtvec;
      `EXU_CSR_MEPC:    return sh_mepc;
      `EXU_CSR_MCAUSE:  return sh_mcause;
      default:          return '0;
    endcase
  endfunction

  task automatic csr_update(input logic [11:0] addr, input logic [XL-1:0] val);
    case (addr)
      `EXU_CSR_MSTATUS: sh_mstatus = val;
      `EXU_CSR_MTVEC:   sh_mtvec   = val;
      `EXU_CSR_MEPC:    sh_mepc    = val;
      `EXU_CSR_MCAUSE:  sh_mcause  = val;
      default:          ;
    endcase
  endtask

  function automatic int unsigned rand_below(int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [XL-1:0] rand_pc();
    return XL'($random(seed)) & ~XL'(3);
  endfunction

  function automatic logic [XL-1:0] rand_imm();
    logic [11:0] r;
    r = 12'($random(seed));
    return {{(XL-12){r[11]}}, r[11:1], 1'b0};
  endfunction

  task automatic check_value(input string what, input logic [XL-1:0] got,
                             input logic [XL-1:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one instruction from acceptance to retirement.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic issue(input instr_class_e cls, input alu_op_e op, input sys_op_e sys,
                       input logic [XL-1:0] s1, input logic [XL-1:0] s2,
                       input logic [XL-1:0] base, input logic [XL-1:0] imm,
                       input logic [XL-1:0] pc, input logic [11:0] csr);
    logic [XL-1:0] target;
    logic [XL-1:0] exp_wdata;
    logic [XL-1:0] exp_npc;
    logic [XL-1:0] old_csr;
    logic          chk_wdata;
    logic          taken;
    logic [4:0]    rd;
    logic          rd_wen;
    int            idx;
    int            lat;
    int            stall;
    target    = base + imm;
    idx       = int'((target >> 2) % `EXU_DMEM_WORDS);
    rd        = 5'(rand_below(32));
    rd_wen    = 1'(rand_below(2));
    exp_npc   = pc + 4;
    exp_wdata = alu_model(op, s1, s2);
    chk_wdata = (cls == CLS_ALU);
    old_csr   = csr_model(csr);
    case (cls)
      CLS_LOAD: begin
        exp_wdata = shadow_mem[idx];
        chk_wdata = 1'b1;
      end
      CLS_BRANCH: begin
        taken = (op == SUB) ? (exp_wdata == '0) :
                (op inside {XOR, SLT, SLTU, SGE, SGEU}) && (exp_wdata != '0);
        exp_npc = taken ? target : pc + 4;
      end
      CLS_JUMP: begin
        exp_wdata = pc + 4;
        chk_wdata = 1'b1;
        exp_npc   = target;
      end
      CLS_SYSTEM: begin
        if (sys inside {SYS_CSRRW, SYS_CSRRS, SYS_CSRRC}) begin
          exp_wdata = old_csr;
          chk_wdata = 1'b1;
        end else if (sys == SYS_ECALL) begin
          exp_npc = sh_mtvec;
        end else if (sys == SYS_MRET) begin
          exp_npc = sh_mepc;
        end
      end
      default: ;
    endcase

    cls_i      = cls;
    alu_op_i   = op;
    sys_op_i   = sys;
    rd_i       = rd;
    rd_wen_i   = rd_wen;
    src1_i     = s1;
    src2_i     = s2;
    base_i     = base;
    imm_i      = imm;
    pc_i       = pc;
    csr_addr_i = csr;
    in_valid_i = 1'b1;
    while (!in_ready_o) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    in_valid_i = 1'b0;
    lat = 1;
    while (!out_valid_o) begin
      @(posedge clk);
      #1;
      lat++;
    end
    check_value("writeback latency", XL'(lat),
                XL'((cls == CLS_LOAD || cls == CLS_STORE) ? 2 : 1));

    // the same values must hold through every stalled cycle.
    stall = (stall_max > 0) ? int'(rand_below(stall_max + 1)) : 0;
    for (int i = 0; i <= stall; i++) begin
      check_value("out_valid_o", XL'(out_valid_o), XL'(1));
      if (chk_wdata) begin
        check_value("rd_wdata_o", rd_wdata_o, exp_wdata);
      end
      check_value("npc_o", npc_o, exp_npc);
      check_value("ebreak_o", XL'(ebreak_o), XL'(cls == CLS_SYSTEM && sys == SYS_EBREAK));
      check_value("rd_o", XL'(rd_o), XL'(rd));
      check_value("rd_wen_o", XL'(rd_wen_o), XL'(rd_wen));
      out_ready_i = (i == stall);
      @(posedge clk);
      #1;
    end
    out_ready_i = 1'b0;
    check_value("in_ready_o after retirement", XL'(in_ready_o), XL'(1));

    if (cls == CLS_STORE) begin
      shadow_mem[idx] = s2;
    end
    if (cls == CLS_SYSTEM) begin
      case (sys)
        SYS_CSRRW: csr_update(csr, s1);
        SYS_CSRRS: csr_update(csr, old_csr | s1);
        SYS_CSRRC: csr_update(csr, old_csr & ~s1);
        SYS_ECALL: begin
          sh_mepc   = pc;
          sh_mcause = `EXU_CAUSE_ECALL;
        end
        SYS_MRET: begin
          sh_mstatus[3] = sh_mstatus[7];
          sh_mstatus[7] = 1'b1;
        end
        default: ;
      endcase
    end
  endtask

  task automatic csr_op(input sys_op_e sys, input logic [11:0] addr,
                        input logic [XL-1:0] val);
    issue(CLS_SYSTEM, ADD, sys, val, '0, '0, '0, rand_pc(), addr);
  endtask

  task automatic read_all_csrs();
    csr_op(SYS_CSRRS, `EXU_CSR_MSTATUS, '0);
    csr_op(SYS_CSRRS, `EXU_CSR_MTVEC, '0);
    csr_op(SYS_CSRRS, `EXU_CSR_MEPC, '0);
    csr_op(SYS_CSRRS, `EXU_CSR_MCAUSE, '0);
  endtask

  task automatic store_load_pair();
    logic [XL-1:0] addr;
    logic [XL-1:0] imm;
    addr = XL'(rand_below(`EXU_DMEM_WORDS) * 4);
    imm  = rand_imm();
    issue(CLS_STORE, ADD, SYS_NONE, '0, $random(seed), addr - imm, imm, rand_pc(), '0);
    imm  = rand_imm();
    issue(CLS_LOAD, ADD, SYS_NONE, '0, '0, addr - imm, imm, rand_pc(), '0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic [XL-1:0] a;
    logic [XL-1:0] b;
    logic [XL-1:0] imm;
    logic [XL-1:0] pc;
    seed        = 32'h7329_7334;
    errors      = 0;
    stall_max   = 0;
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    cls_i       = CLS_ALU;
    alu_op_i    = ADD;
    sys_op_i    = SYS_NONE;
    rd_i        = '0;
    rd_wen_i    = 1'b0;
    src1_i      = '0;
    src2_i      = '0;
    base_i      = '0;
    imm_i       = '0;
    pc_i        = '0;
    csr_addr_i  = '0;
    out_ready_i = 1'b0;
    sh_mstatus  = '0;
    sh_mtvec    = '0;
    sh_mepc     = '0;
    sh_mcause   = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("in_ready_o after reset", XL'(in_ready_o), XL'(1));
    check_value("out_valid_o after reset", XL'(out_valid_o), XL'(0));

    repeat (N_ALU) begin
      issue(CLS_ALU, alu_op_e'(rand_below(12)), SYS_NONE, $random(seed), $random(seed),
            $random(seed), $random(seed), rand_pc(), '0);
    end

    // equal, then both orders of two different operands.
    foreach (br_ops[i]) begin
      a = $random(seed);
      b = a ^ (XL'($random(seed)) | XL'(1));
      issue(CLS_BRANCH, br_ops[i], SYS_NONE, a, a, rand_pc(), rand_imm(), rand_pc(), '0);
      issue(CLS_BRANCH, br_ops[i], SYS_NONE, a, b, rand_pc(), rand_imm(), rand_pc(), '0);
      issue(CLS_BRANCH, br_ops[i], SYS_NONE, b, a, rand_pc(), rand_imm(), rand_pc(), '0);
    end
    repeat (4) begin
      issue(CLS_JUMP, ADD, SYS_NONE, '0, '0, rand_pc(), rand_imm(), rand_pc(), '0);
    end

    // all stores first, then the loads from the same words.
    repeat (N_MEM) begin
      a   = XL'(rand_below(`EXU_DMEM_WORDS) * 4);
      imm = rand_imm();
      addr_q.push_back(a);
      issue(CLS_STORE, ADD, SYS_NONE, '0, $random(seed), a - imm, imm, rand_pc(), '0);
    end
    foreach (addr_q[i]) begin
      imm = rand_imm();
      issue(CLS_LOAD, ADD, SYS_NONE, '0, '0, addr_q[i] - imm, imm, rand_pc(), '0);
    end

    csr_op(SYS_CSRRW, `EXU_CSR_MTVEC, rand_pc());
    csr_op(SYS_CSRRS, `EXU_CSR_MSTATUS, 32'h0000_0088);
    csr_op(SYS_CSRRC, `EXU_CSR_MSTATUS, 32'h0000_0008);
    csr_op(SYS_CSRRW, `EXU_CSR_MEPC, $random(seed));
    read_all_csrs();
    pc = rand_pc();
    issue(CLS_SYSTEM, ADD, SYS_ECALL, '0, '0, '0, '0, pc, '0);
    issue(CLS_SYSTEM, ADD, SYS_MRET, '0, '0, '0, '0, rand_pc(), '0);
    read_all_csrs();
    issue(CLS_SYSTEM, ADD, SYS_EBREAK, '0, '0, '0, '0, rand_pc(), '0);
    read_all_csrs();

    // mret after mpie is cleared exposes a second commit through mie.
    stall_max = 6;
    repeat (N_ROUNDS) begin
      issue(CLS_ALU, alu_op_e'(rand_below(12)), SYS_NONE, $random(seed), $random(seed),
            '0, '0, rand_pc(), '0);
      store_load_pair();
      issue(CLS_SYSTEM, ADD, SYS_ECALL, '0, '0, '0, '0, rand_pc(), '0);
      csr_op(SYS_CSRRC, `EXU_CSR_MSTATUS, 32'h0000_0080);
      issue(CLS_SYSTEM, ADD, SYS_MRET, '0, '0, '0, '0, rand_pc(), '0);
      csr_op(SYS_CSRRS, `EXU_CSR_MSTATUS, '0);
      csr_op(SYS_CSRRS, `EXU_CSR_MCAUSE, '0);
    end

    repeat (3) @(posedge clk);
    $display("value errors: %0d, assertion errors: %0d", errors,
             dut0.u_asserts.fail_count);
    if (errors == 0 && dut0.u_asserts.fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (5 + N_INSTR * 20) @(posedge clk);
    $display("watchdog expired, the stage stopped answering after %0d cycles",
             5 + N_INSTR * 20);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hdl
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_csr_file.sv
hdl/exu_branch_unit.sv
hdl/exu_stage.sv
hdl/exu_lsu.sv
hdl/exu_top.sv
testbench/exu_asserts.sv
testbench/exu_tb.sv
